// File: files.f
hw/sd_pkg.sv
hw/vector_pkg.sv
hw/run_timer.sv
hw/block_cursor.sv
hw/vector_regs.sv
hw/autotest_ctrl.sv
hw/autotest_top.sv
test/sd_card_model.sv
test/tb_autotest.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_autotest
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_autotest.sv
// autotest testbench with sd card and cipher models and assertion checks
module tb_autotest;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          TIMEOUT = 200;
  localparam logic [31:0] BASE    = sd_pkg::DEFAULT_BASE_BLOCK;
  localparam int          N_TESTS = 4;

  logic        clk;
  logic        rst;
  logic        spi_busy;
  logic [7:0]  spi_rdata;
  logic        spi_rst;
  logic        spi_r_block;
  logic        spi_r_byte;
  logic        spi_w_block;
  logic        spi_w_byte;
  logic [7:0]  spi_wdata;
  logic [31:0] spi_addr;
  logic        uut_rst;
  logic [63:0] uut_block_o;
  logic [79:0] uut_key_o;
  logic        uut_decrypt;
  logic [63:0] uut_block_i;
  logic        uut_end_enc;
  logic        uut_end_dec;
  logic        halted;
  logic [2:0]  lat;

  logic [31:0] lfsr_state;
  logic [7:0]  vec [N_TESTS][512];
  logic [63:0] exp_blk [N_TESTS];
  logic [79:0] exp_key [N_TESTS];
  logic        exp_dir [N_TESTS];
  logic        sig_good [N_TESTS];
  logic        hang [N_TESTS];
  logic        seen_req;
  logic        any_req;
  logic        running;
  int          run_len;
  int          cur_t;

  assign any_req = spi_rst | spi_r_block | spi_r_byte | spi_w_block | spi_w_byte;
  assign cur_t   = int'(spi_addr - BASE);

  autotest_top #(
    .TIMEOUT_CYCLES (TIMEOUT)
  ) i_autotest_top (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy),
    .spi_data_i       (spi_rdata),
    .spi_rst_o        (spi_rst),
    .spi_r_block_o    (spi_r_block),
    .spi_r_byte_o     (spi_r_byte),
    .spi_w_block_o    (spi_w_block),
    .spi_w_byte_o     (spi_w_byte),
    .spi_data_o       (spi_wdata),
    .spi_block_addr_o (spi_addr),
    .uut_rst_o        (uut_rst),
    .uut_block_o      (uut_block_o),
    .uut_key_o        (uut_key_o),
    .uut_decrypt_o    (uut_decrypt),
    .uut_block_i      (uut_block_i),
    .uut_end_enc_i    (uut_end_enc),
    .uut_end_dec_i    (uut_end_dec),
    .halted_o         (halted)
  );

  sd_card_model i_sd (
    .clk           (clk),
    .rst           (rst),
    .lat_i         (lat),
    .spi_rst_i     (spi_rst),
    .spi_r_block_i (spi_r_block),
    .spi_r_byte_i  (spi_r_byte),
    .spi_w_block_i (spi_w_block),
    .spi_w_byte_i  (spi_w_byte),
    .spi_data_i    (spi_wdata),
    .block_addr_i  (spi_addr),
    .spi_busy_o    (spi_busy),
    .spi_data_o    (spi_rdata)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // reference cipher mixing block and key by xor, rotate and add, inverse for decrypt
  function automatic logic [63:0] cipher_out(input logic [63:0] b, input logic [79:0] k,
                                             input logic dec);
    logic [63:0] x;
    if (!dec)
    begin
      x = b ^ k[63:0];
      return {x[50:0], x[63:51]} + k[79:16];
    end
    x = b - k[79:16];
    return {x[12:0], x[63:13]} ^ k[63:0];
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
    $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic build_vector(input int t, input logic good, input logic dir,
                              input logic never_end);
    logic [31:0] r;
    logic [31:0] sig;
    sig = good ? 32'hAABB_CCDD : 32'hAABB_CCDE;
    for (int i = 0; i < 512; i++)
    begin
      draw_bits(8, r);
      vec[t][i] = r[7:0];
    end
    draw_bits(32, r);
    exp_blk[t][63:32] = r;
    draw_bits(32, r);
    exp_blk[t][31:0] = r;
    draw_bits(16, r);
    exp_key[t][79:64] = r[15:0];
    draw_bits(32, r);
    exp_key[t][63:32] = r;
    draw_bits(32, r);
    exp_key[t][31:0] = r;
    for (int i = 0; i < 4; i++)
      vec[t][i] = sig[31-8*i -: 8];
    for (int i = 0; i < 8; i++)
      vec[t][5+i] = exp_blk[t][63-8*i -: 8];
    for (int i = 0; i < 10; i++)
      vec[t][13+i] = exp_key[t][79-8*i -: 8];
    vec[t][23]  = {7'd0, dir};
    exp_dir[t]  = dir;
    sig_good[t] = good;
    hang[t]     = never_end;
    for (int i = 0; i < 512; i++)
      i_sd.put_byte(BASE + t, i, vec[t][i]);
  endtask

  task automatic check_block(input int t);
    logic [63:0] res;
    logic [7:0]  exp;
    logic [7:0]  got;
    res = cipher_out(exp_blk[t], exp_key[t], exp_dir[t]);
    a_wr_addr: assert (i_sd.last_wr_addr == BASE + t)
      else report_mismatch("write address", BASE + t, i_sd.last_wr_addr);
    for (int i = 0; i < 512; i++)
    begin
      if (i < 24 && i != 4)
        exp = vec[t][i];
      else if (i >= 24 && i < 32)
        exp = res[8*(i-24) +: 8];
      else
        exp = 8'h00;
      got = i_sd.get_byte(BASE + t, i);
      a_wr_byte: assert (got == exp)
        else report_mismatch($sformatf("block %0d byte %0d", t, i), exp, got);
    end
  endtask

  task automatic wait_block_written(input int t);
    int n;
    n = 0;
    while (i_sd.blocks_written <= t)
    begin
      @(posedge clk);
      n++;
      if (n > 60000)
        fail_now($sformatf("timeout waiting for block %0d write-back", t));
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // new sd busy length every cycle
  always @(posedge clk)
  begin : latency
    logic [31:0] v;
    draw_bits(3, v);
    lat = v[2:0];
  end

  always
  begin : cipher
    logic [31:0] v;
    int          wait_n;
    int          cnt;
    @(posedge clk);
    #1;
    if (!uut_rst && !running)
    begin
      running = 1'b1;
      draw_bits(7, v);
      wait_n = int'(v[6:0]) % 100;
      cnt    = 0;
      if (hang[cur_t])
        uut_block_i = cipher_out(uut_block_o, uut_key_o, uut_decrypt);
    end
    else if (running && uut_rst)
    begin
      running     = 1'b0;
      uut_end_enc = 1'b0;
      uut_end_dec = 1'b0;
      uut_block_i = '0;
    end
    if (running && !hang[cur_t])
    begin
      // the other direction's flag stays high as a decoy until the end
      uut_end_enc = uut_decrypt ? (cnt < wait_n) : (cnt == wait_n);
      uut_end_dec = uut_decrypt ? (cnt == wait_n) : (cnt < wait_n);
      if (cnt == wait_n)
        uut_block_i = cipher_out(uut_block_o, uut_key_o, uut_decrypt);
      cnt++;
    end
  end

  always @(posedge clk)
  begin
    if (rst)
      seen_req <= 1'b0;
    else if (any_req)
      seen_req <= 1'b1;
    if (rst || uut_rst)
      run_len <= 0;
    else
      run_len <= run_len + 1;
  end

  a_first_req: assert property (@(posedge clk) disable iff (rst)
    (!seen_req && any_req) |-> (spi_rst && !spi_r_block && !spi_w_block))
    else fail_now("first sd request after reset is not the host reset");
  a_run_gate: assert property (@(posedge clk) disable iff (rst)
    !uut_rst |-> (sig_good[cur_t] && i_sd.rd_idx == 511))
    else fail_now("cipher left reset before a valid block was fully read");
  a_block: assert property (@(posedge clk) disable iff (rst)
    !uut_rst |-> uut_block_o == exp_blk[cur_t])
    else report_mismatch("cipher block input", exp_blk[cur_t], uut_block_o);
  a_key: assert property (@(posedge clk) disable iff (rst)
    !uut_rst |-> uut_key_o == exp_key[cur_t])
    else report_mismatch("cipher key", exp_key[cur_t], uut_key_o);
  a_dir: assert property (@(posedge clk) disable iff (rst)
    !uut_rst |-> uut_decrypt == exp_dir[cur_t])
    else report_mismatch("cipher direction", exp_dir[cur_t], uut_decrypt);
  a_timeout: assert property (@(posedge clk) disable iff (rst)
    ($rose(uut_rst) && hang[cur_t]) |-> run_len == TIMEOUT)
    else report_mismatch("timeout run length", TIMEOUT, run_len);
  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halted |-> (!any_req && !sig_good[cur_t]))
    else fail_now("sd request or good signature while halted");
  a_halt_hold: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else fail_now("halted_o dropped without reset");
  a_halt_writes: assert property (@(posedge clk) disable iff (rst)
    halted |-> i_sd.blocks_written == N_TESTS - 1)
    else fail_now("unexpected write-back count once halted");

  initial
  begin
    int n;
    lfsr_state  = 32'h03d1779a;
    rst         = 1'b1;
    lat         = 3'd0;
    uut_block_i = '0;
    uut_end_enc = 1'b0;
    uut_end_dec = 1'b0;
    running     = 1'b0;
    build_vector(0, 1'b1, 1'b0, 1'b0);
    build_vector(1, 1'b1, 1'b1, 1'b0);
    build_vector(2, 1'b1, 1'b0, 1'b1);
    build_vector(3, 1'b0, 1'b1, 1'b0);
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int t = 0; t < 3; t++)
    begin
      wait_block_written(t);
      check_block(t);
    end
    n = 0;
    while (!halted)
    begin
      @(posedge clk);
      n++;
      if (n > 30000)
        fail_now("timeout waiting for halt on bad signature");
    end
    // quiet period watched by the halt assertions
    repeat (200) @(posedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

// File: test/sd_card_model.sv
// sd card model: block store per address, answers level requests with a busy pulse
module sd_card_model (
  input  logic       clk,
  input  logic       rst,
  input  logic [2:0] lat_i,
  input  logic       spi_rst_i,
  input  logic       spi_r_block_i,
  input  logic       spi_r_byte_i,
  input  logic       spi_w_block_i,
  input  logic       spi_w_byte_i,
  input  logic [7:0] spi_data_i,
  input  logic [31:0] block_addr_i,
  output logic       spi_busy_o,
  output logic [7:0] spi_data_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // key is block address and byte index
  logic [7:0]  store [logic [41:0]];
  logic        rd_open;
  logic        wr_open;
  int          rd_idx;
  int          wr_idx;
  int unsigned blocks_written;
  logic [31:0] last_wr_addr;

  function automatic logic [7:0] get_byte(input logic [31:0] addr, input int idx);
    logic [41:0] key;
    key = {addr, idx[9:0]};
    if (store.exists(key))
      return store[key];
    return 8'h00;
  endfunction

  task automatic put_byte(input logic [31:0] addr, input int idx, input logic [7:0] val);
    store[{addr, idx[9:0]}] = val;
  endtask

  initial
  begin
    spi_busy_o     = 1'b0;
    spi_data_o     = 8'h00;
    rd_open        = 1'b0;
    wr_open        = 1'b0;
    rd_idx         = 0;
    wr_idx         = 0;
    blocks_written = 0;
    last_wr_addr   = '0;
  end

  always
  begin : serve
    logic accepted;
    int   hold;
    @(posedge clk);
    #1;
    accepted = 1'b1;
    if (rst)
    begin
      rd_open  = 1'b0;
      wr_open  = 1'b0;
      accepted = 1'b0;
    end
    else if (!spi_busy_o)
    begin
      if (spi_rst_i)
      begin
        rd_open = 1'b0;
        wr_open = 1'b0;
      end
      else if (spi_r_block_i && !rd_open)
      begin
        rd_open    = 1'b1;
        rd_idx     = 0;
        spi_data_o = get_byte(block_addr_i, 0);
      end
      else if (spi_r_byte_i)
      begin
        rd_idx     = rd_idx + 1;
        spi_data_o = get_byte(block_addr_i, rd_idx);
      end
      else if (spi_w_block_i && !wr_open)
      begin
        wr_open = 1'b1;
        wr_idx  = 0;
      end
      else if (spi_w_byte_i)
      begin
        put_byte(block_addr_i, wr_idx, spi_data_i);
        wr_idx = wr_idx + 1;
        if (wr_idx == 512)
        begin
          wr_open        = 1'b0;
          last_wr_addr   = block_addr_i;
          blocks_written = blocks_written + 1;
        end
      end
      else
        accepted = 1'b0;
    end
    else
      accepted = 1'b0;
    if (accepted)
    begin
      // busy spans at least one full cycle
      hold       = int'(lat_i);
      spi_busy_o = 1'b1;
      repeat (hold + 1) @(posedge clk);
      #1;
      spi_busy_o = 1'b0;
    end
  end

endmodule

// File: hw/autotest_top.sv
// self-test top: controller and datapath between the sd host and the cipher
module autotest_top #(
  parameter int unsigned         TIMEOUT_CYCLES = 115343360,
  parameter sd_pkg::block_addr_t BASE_BLOCK     = sd_pkg::DEFAULT_BASE_BLOCK
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           spi_busy_i,
  input  sd_pkg::byte_t                  spi_data_i,
  output logic                           spi_rst_o,
  output logic                           spi_r_block_o,
  output logic                           spi_r_byte_o,
  output logic                           spi_w_block_o,
  output logic                           spi_w_byte_o,
  output sd_pkg::byte_t                  spi_data_o,
  output sd_pkg::block_addr_t            spi_block_addr_o,
  output logic                           uut_rst_o,
  output logic [vector_pkg::BLOCK_W-1:0] uut_block_o,
  output logic [vector_pkg::KEY_W-1:0]   uut_key_o,
  output logic                           uut_decrypt_o,
  input  logic [vector_pkg::BLOCK_W-1:0] uut_block_i,
  input  logic                           uut_end_enc_i,
  input  logic                           uut_end_dec_i,
  output logic                           halted_o
);
  import sd_pkg::*;
  import vector_pkg::*;

  logic      regs_clear;
  logic      capture;
  logic      result_load;
  logic      idx_clear;
  logic      idx_step;
  logic      block_step;
  logic      run;
  logic      timeout;
  logic      last_byte;
  logic      sig_ok;
  dir_e      dir;
  byte_idx_t byte_idx;

  assign uut_decrypt_o = dir;

  autotest_ctrl i_autotest_ctrl (
    .clk           (clk),
    .rst           (rst),
    .spi_busy_i    (spi_busy_i),
    .last_byte_i   (last_byte),
    .sig_ok_i      (sig_ok),
    .dir_i         (dir),
    .uut_end_enc_i (uut_end_enc_i),
    .uut_end_dec_i (uut_end_dec_i),
    .timeout_i     (timeout),
    .spi_rst_o     (spi_rst_o),
    .spi_r_block_o (spi_r_block_o),
    .spi_r_byte_o  (spi_r_byte_o),
    .spi_w_block_o (spi_w_block_o),
    .spi_w_byte_o  (spi_w_byte_o),
    .uut_rst_o     (uut_rst_o),
    .halted_o      (halted_o),
    .regs_clear_o  (regs_clear),
    .capture_o     (capture),
    .result_load_o (result_load),
    .idx_clear_o   (idx_clear),
    .idx_step_o    (idx_step),
    .block_step_o  (block_step),
    .run_o         (run)
  );

  vector_regs i_vector_regs (
    .clk           (clk),
    .rst           (rst),
    .clear_i       (regs_clear),
    .capture_i     (capture),
    .byte_idx_i    (byte_idx),
    .data_i        (spi_data_i),
    .result_load_i (result_load),
    .result_i      (uut_block_i),
    .block_o       (uut_block_o),
    .key_o         (uut_key_o),
    .dir_o         (dir),
    .sig_ok_o      (sig_ok),
    .wr_byte_o     (spi_data_o)
  );

  block_cursor #(
    .BASE_BLOCK (BASE_BLOCK)
  ) i_block_cursor (
    .clk          (clk),
    .rst          (rst),
    .idx_clear_i  (idx_clear),
    .idx_step_i   (idx_step),
    .block_step_i (block_step),
    .byte_idx_o   (byte_idx),
    .last_byte_o  (last_byte),
    .block_addr_o (spi_block_addr_o)
  );

  run_timer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) i_run_timer (
    .clk       (clk),
    .rst       (rst),
    .run_i     (run),
    .timeout_o (timeout)
  );

endmodule

// File: hw/autotest_ctrl.sv
// self-test controller: sd reset, block read, signature check, cipher run and write-back
module autotest_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             spi_busy_i,
  input  logic             last_byte_i,
  input  logic             sig_ok_i,
  input  vector_pkg::dir_e dir_i,
  input  logic             uut_end_enc_i,
  input  logic             uut_end_dec_i,
  input  logic             timeout_i,
  output logic             spi_rst_o,
  output logic             spi_r_block_o,
  output logic             spi_r_byte_o,
  output logic             spi_w_block_o,
  output logic             spi_w_byte_o,
  output logic             uut_rst_o,
  output logic             halted_o,
  output logic             regs_clear_o,
  output logic             capture_o,
  output logic             result_load_o,
  output logic             idx_clear_o,
  output logic             idx_step_o,
  output logic             block_step_o,
  output logic             run_o
);
  import vector_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE,
    S_SD_RST,
    S_SD_RST_WAIT,
    S_RD_OPEN,
    S_RD_OPEN_WAIT,
    S_RD_CAPTURE,
    S_RD_BYTE,
    S_RD_BYTE_WAIT,
    S_CHECK,
    S_RUN,
    S_CAPTURE,
    S_WR_OPEN,
    S_WR_OPEN_WAIT,
    S_WR_BYTE,
    S_WR_BYTE_WAIT,
    S_HALT
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   end_hit;

  // only the flag of the selected direction ends the run
  assign end_hit = (dir_i == DIR_ENC) ? uut_end_enc_i : uut_end_dec_i;

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= S_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d       = state_q;
    spi_rst_o     = 1'b0;
    spi_r_block_o = 1'b0;
    spi_r_byte_o  = 1'b0;
    spi_w_block_o = 1'b0;
    spi_w_byte_o  = 1'b0;
    uut_rst_o     = 1'b1;
    halted_o      = 1'b0;
    regs_clear_o  = 1'b0;
    capture_o     = 1'b0;
    result_load_o = 1'b0;
    idx_clear_o   = 1'b0;
    idx_step_o    = 1'b0;
    block_step_o  = 1'b0;
    run_o         = 1'b0;

    case (state_q)
      S_IDLE:
      begin
        regs_clear_o = 1'b1;
        idx_clear_o  = 1'b1;
        state_d      = S_SD_RST;
      end
      S_SD_RST:
      begin
        spi_rst_o = 1'b1;
        if (spi_busy_i)
          state_d = S_SD_RST_WAIT;
      end
      S_SD_RST_WAIT:
      begin
        if (!spi_busy_i)
          state_d = S_RD_OPEN;
      end
      S_RD_OPEN:
      begin
        spi_r_block_o = 1'b1;
        if (spi_busy_i)
          state_d = S_RD_OPEN_WAIT;
      end
      S_RD_OPEN_WAIT:
      begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i)
          state_d = S_RD_CAPTURE;
      end
      S_RD_CAPTURE:
      begin
        spi_r_block_o = 1'b1;
        capture_o     = 1'b1;
        if (last_byte_i)
          state_d = S_CHECK;
        else
        begin
          idx_step_o = 1'b1;
          state_d    = S_RD_BYTE;
        end
      end
      S_RD_BYTE:
      begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i)
          state_d = S_RD_BYTE_WAIT;
      end
      S_RD_BYTE_WAIT:
      begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i)
          state_d = S_RD_CAPTURE;
      end
      S_CHECK:
      begin
        state_d = sig_ok_i ? S_RUN : S_HALT;
      end
      S_RUN:
      begin
        uut_rst_o = 1'b0;
        run_o     = 1'b1;
        // result is taken on the end cycle, or whatever is there at timeout
        if (end_hit || timeout_i)
        begin
          result_load_o = 1'b1;
          state_d       = S_CAPTURE;
        end
      end
      S_CAPTURE:
      begin
        idx_clear_o = 1'b1;
        state_d     = S_WR_OPEN;
      end
      S_WR_OPEN:
      begin
        spi_w_block_o = 1'b1;
        if (spi_busy_i)
          state_d = S_WR_OPEN_WAIT;
      end
      S_WR_OPEN_WAIT:
      begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i)
          state_d = S_WR_BYTE;
      end
      S_WR_BYTE:
      begin
        spi_w_block_o = 1'b1;
        spi_w_byte_o  = 1'b1;
        if (spi_busy_i)
          state_d = S_WR_BYTE_WAIT;
      end
      S_WR_BYTE_WAIT:
      begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i)
        begin
          if (last_byte_i)
          begin
            // next address only once the whole block is out
            block_step_o = 1'b1;
            state_d      = S_IDLE;
          end
          else
          begin
            idx_step_o = 1'b1;
            state_d    = S_WR_BYTE;
          end
        end
      end
      S_HALT:
      begin
        halted_o = 1'b1;
      end
      default:
      begin
        state_d = S_IDLE;
      end
    endcase
  end

endmodule

// File: hw/vector_regs.sv
// vector registers: byte-wise field capture, signature compare, result hold, write-back mux
module vector_regs (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           clear_i,
  input  logic                           capture_i,
  input  sd_pkg::byte_idx_t              byte_idx_i,
  input  sd_pkg::byte_t                  data_i,
  input  logic                           result_load_i,
  input  logic [vector_pkg::BLOCK_W-1:0] result_i,
  output logic [vector_pkg::BLOCK_W-1:0] block_o,
  output logic [vector_pkg::KEY_W-1:0]   key_o,
  output vector_pkg::dir_e               dir_o,
  output logic                           sig_ok_o,
  output sd_pkg::byte_t                  wr_byte_o
);
  import sd_pkg::*;
  import vector_pkg::*;

  localparam int SIG_N  = $bits(SIGNATURE) / 8;
  localparam int BLK_N  = BLOCK_W / 8;
  localparam int KEY_N  = KEY_W / 8;
  localparam int SIG_SW = $clog2(SIG_N);
  localparam int BLK_SW = $clog2(BLK_N);
  localparam int KEY_SW = $clog2(KEY_N);
  localparam int RES_SW = $clog2(RESULT_END - RESULT_OFS);

  byte_t              sig_q [SIG_N];
  byte_t              blk_q [BLK_N];
  byte_t              key_q [KEY_N];
  byte_t              dir_q;
  logic [BLOCK_W-1:0] result_q;
  logic [31:0]        sig_word;

  byte_idx_t rel_sig;
  byte_idx_t rel_blk;
  byte_idx_t rel_key;
  byte_idx_t rel_res;
  logic      in_sig;
  logic      in_blk;
  logic      in_key;
  logic      in_dir;
  logic      in_res;

  // index below a field offset wraps high, so one compare covers both bounds
  assign rel_sig = byte_idx_i - byte_idx_t'(SIG_OFS);
  assign rel_blk = byte_idx_i - byte_idx_t'(BLOCK_I_OFS);
  assign rel_key = byte_idx_i - byte_idx_t'(KEY_OFS);
  assign rel_res = byte_idx_i - byte_idx_t'(RESULT_OFS);
  assign in_sig  = rel_sig < byte_idx_t'(SIG_N);
  assign in_blk  = rel_blk < byte_idx_t'(BLK_N);
  assign in_key  = rel_key < byte_idx_t'(KEY_N);
  assign in_dir  = byte_idx_i == byte_idx_t'(DIR_OFS);
  assign in_res  = rel_res < byte_idx_t'(RESULT_END - RESULT_OFS);

  always_ff @(posedge clk)
  begin
    if (rst || clear_i)
    begin
      sig_q <= '{default: '0};
      blk_q <= '{default: '0};
      key_q <= '{default: '0};
      dir_q <= '0;
    end
    else if (capture_i)
    begin
      if (in_sig)
        sig_q[rel_sig[SIG_SW-1:0]] <= data_i;
      if (in_blk)
        blk_q[rel_blk[BLK_SW-1:0]] <= data_i;
      if (in_key)
        key_q[rel_key[KEY_SW-1:0]] <= data_i;
      if (in_dir)
        dir_q <= data_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || clear_i)
      result_q <= '0;
    else if (result_load_i)
      result_q <= result_i;
  end

  // first byte of each field is the most significant
  always_comb
  begin
    for (int i = 0; i < SIG_N; i++)
      sig_word[31-8*i -: 8] = sig_q[i];
    for (int i = 0; i < BLK_N; i++)
      block_o[BLOCK_W-1-8*i -: 8] = blk_q[i];
    for (int i = 0; i < KEY_N; i++)
      key_o[KEY_W-1-8*i -: 8] = key_q[i];
  end

  assign sig_ok_o = sig_word == SIGNATURE;
  assign dir_o    = dir_e'(dir_q[0]);

  // byte 4 and the tail of the block go out as zero
  always_comb
  begin
    wr_byte_o = '0;
    if (in_sig)
      wr_byte_o = sig_q[rel_sig[SIG_SW-1:0]];
    else if (in_blk)
      wr_byte_o = blk_q[rel_blk[BLK_SW-1:0]];
    else if (in_key)
      wr_byte_o = key_q[rel_key[KEY_SW-1:0]];
    else if (in_dir)
      wr_byte_o = dir_q;
    else if (in_res)
      wr_byte_o = result_q[8*rel_res[RES_SW-1:0] +: 8];
  end

endmodule

// File: hw/block_cursor.sv
// block cursor: byte position within the block and sd block address
module block_cursor #(
  parameter sd_pkg::block_addr_t BASE_BLOCK = sd_pkg::DEFAULT_BASE_BLOCK
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                idx_clear_i,
  input  logic                idx_step_i,
  input  logic                block_step_i,
  output sd_pkg::byte_idx_t   byte_idx_o,
  output logic                last_byte_o,
  output sd_pkg::block_addr_t block_addr_o
);
  import sd_pkg::*;

  byte_idx_t   idx_q;
  block_addr_t done_q;

  always_ff @(posedge clk)
  begin
    if (rst || idx_clear_i)
      idx_q <= '0;
    else if (idx_step_i)
      idx_q <= idx_q + 1'b1;
  end

  // completed blocks
  always_ff @(posedge clk)
  begin
    if (rst)
      done_q <= '0;
    else if (block_step_i)
      done_q <= done_q + 1'b1;
  end

  assign byte_idx_o   = idx_q;
  assign last_byte_o  = idx_q == byte_idx_t'(BLOCK_BYTES - 1);
  assign block_addr_o = BASE_BLOCK + done_q;

endmodule

// File: hw/run_timer.sv
// run timer: counts cipher run cycles and flags the timeout
module run_timer #(
  parameter int unsigned TIMEOUT_CYCLES = 115343360
) (
  input  logic clk,
  input  logic rst,
  input  logic run_i,
  output logic timeout_o
);
  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(TIMEOUT_CYCLES - 1);

  logic [CNT_W-1:0] count_q;

  // saturates on the last run cycle
  always_ff @(posedge clk)
  begin
    if (rst || !run_i)
      count_q <= '0;
    else if (count_q != LAST)
      count_q <= count_q + 1'b1;
  end

  assign timeout_o = run_i && (count_q == LAST);

endmodule

// File: hw/vector_pkg.sv
// test-vector package: block layout, cipher field widths, signature and direction
package vector_pkg;

  // byte offsets inside the test block
  localparam int SIG_OFS     = 0;
  localparam int BLOCK_I_OFS = 5;
  localparam int KEY_OFS     = 13;
  localparam int DIR_OFS     = 23;
  localparam int RESULT_OFS  = 24;
  localparam int RESULT_END  = 32;

  // cipher widths
  localparam int BLOCK_W = 64;
  localparam int KEY_W   = 80;

  // byte 0 carries the top byte
  localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;

  typedef enum logic {
    DIR_ENC = 1'b0,
    DIR_DEC = 1'b1
  } dir_e;

endpackage

// File: hw/sd_pkg.sv
// sd host package: block geometry, data byte and block address types
package sd_pkg;

  // bytes per sd block
  localparam int BLOCK_BYTES = 512;

  typedef logic [7:0] byte_t;

  typedef logic [31:0] block_addr_t;

  // index within one block
  typedef logic [9:0] byte_idx_t;

  // first block read by the self-test
  localparam block_addr_t DEFAULT_BASE_BLOCK = 32'h0010_0000;

endpackage
